/* axi_pkg.sv */
package axi_pkg;

  // response codes, only okay is named
  localparam logic [1:0] resp_okay = 2'b00;

  // transfer size, log2 of bytes per beat
  localparam logic [2:0] size_byte = 3'd0;
  localparam logic [2:0] size_half = 3'd1;
  localparam logic [2:0] size_word = 3'd2;

  // single-beat address channels, len and burst fixed at 0
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_aw_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;  // one bit per byte lane
  } axi_w_t;

  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

/* core_bus_pkg.sv */
package core_bus_pkg;

  // machine timer words, decoded in front of the AXI master
  localparam logic [31:0] mtime_lo_addr = 32'h0200_0000;
  localparam logic [31:0] mtime_hi_addr = 32'h0200_0004;

  // instruction fetch, always a full word
  typedef struct packed {
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } fetch_rsp_t;

  // load/store, strb is lsb aligned, shifted later by addr[1:0]
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        write;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // aligned word, no sign extension here
    logic        err;
  } lsu_rsp_t;

endpackage

/* req_slot.sv */
`timescale 1ns/1ps

// four-phase endpoint for one core port
module req_slot #(
  parameter type REQ_T = logic,
  parameter type RSP_T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic req_valid_i,
  input  REQ_T req_i,
  output logic ack_o,
  output RSP_T rsp_o,
  output logic pending_o,
  output REQ_T payload_o,
  input  logic done_i,
  input  RSP_T rsp_i
);

  logic capture;

  // new request only once the previous ack has dropped
  assign capture = req_valid_i && !pending_o && !ack_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_o <= 1'b0;
      ack_o     <= 1'b0;
    end else begin
      if (capture) begin
        pending_o <= 1'b1;
      end else if (done_i) begin
        pending_o <= 1'b0;
      end
      if (done_i) begin
        ack_o <= 1'b1;
      end else if (ack_o && !req_valid_i) begin
        ack_o <= 1'b0;  // req gone, close the handshake
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) payload_o <= req_i;
    if (done_i) rsp_o <= rsp_i;  // held while ack is up
  end

endmodule

/* lane_align.sv */
`timescale 1ns/1ps

// 32-bit access onto the 64-bit data bus
module lane_align
  import axi_pkg::*;
(
  input  logic [31:0] addr_i,
  input  logic [3:0]  strb_i,
  input  logic [31:0] wdata_i,
  input  logic        is_fetch_i,
  input  logic [63:0] rdata64_i,
  output logic [2:0]  size_o,
  output logic [63:0] wdata64_o,
  output logic [7:0]  strb64_o,
  output logic [31:0] rword_o
);

  logic [1:0]  offset;
  logic [4:0]  shamt;
  logic [31:0] wdata_sh;
  logic [3:0]  strb_sh;

  assign offset   = addr_i[1:0];
  assign shamt    = {offset, 3'b000};  // bytes to bits
  assign wdata_sh = wdata_i << shamt;
  assign strb_sh  = strb_i << offset;

  always_comb begin
    if (is_fetch_i) begin
      size_o = size_word;
    end else begin
      case (strb_i)
        4'b0001: size_o = size_byte;
        4'b0011: size_o = size_half;
        default: size_o = size_word;
      endcase
    end
  end

  // same word on both halves, strobe picks the live one
  assign wdata64_o = {wdata_sh, wdata_sh};
  assign strb64_o  = addr_i[2] ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};

  // upper half for addresses with bit 2 set
  assign rword_o = addr_i[2] ? rdata64_i[63:32] : rdata64_i[31:0];

endmodule

/* clint_timer.sv */
`timescale 1ns/1ps

// core-local mtime, read and written one 32-bit word at a time
module clint_timer
  import core_bus_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              acc_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              write_i,
  input  logic [31:0]       wdata_i,
  output logic [31:0]       rdata_o
);

  logic [63:0] mtime;
  logic        hit_lo;
  logic        hit_hi;

  assign hit_lo = (addr_i == ADDR_W'(mtime_lo_addr));
  assign hit_hi = (addr_i == ADDR_W'(mtime_hi_addr));

  // a written word replaces the count for that cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (acc_i && write_i && hit_lo) begin
      mtime <= {mtime[63:32], wdata_i};
    end else if (acc_i && write_i && hit_hi) begin
      mtime <= {wdata_i, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // read data valid the cycle after the strobe
  always_ff @(posedge clk) begin
    if (acc_i && !write_i) begin
      if (hit_hi) begin
        rdata_o <= mtime[63:32];
      end else if (hit_lo) begin
        rdata_o <= mtime[31:0];
      end
    end
  end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

// one transaction at a time, load/store wins over fetch
module bus_arbiter
  import axi_pkg::*;
  import core_bus_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_pend_i,
  input  fetch_req_t        fetch_pay_i,
  output logic              fetch_done_o,
  output fetch_rsp_t        fetch_rsp_o,
  input  logic              lsu_pend_i,
  input  lsu_req_t          lsu_pay_i,
  output logic              lsu_done_o,
  output lsu_rsp_t          lsu_rsp_o,
  output axi_ar_t           ar_o,
  output logic              arvalid_o,
  input  logic              arready_i,
  input  axi_r_t            r_i,
  input  logic              rvalid_i,
  output axi_aw_t           aw_o,
  output logic              awvalid_o,
  input  logic              awready_i,
  output axi_w_t            w_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  axi_b_t            b_i,
  input  logic              bvalid_i,
  output logic              rready_o,
  output logic              bready_o,
  output logic [31:0]       la_addr_o,
  output logic [3:0]        la_strb_o,
  output logic [31:0]       la_wdata_o,
  output logic              la_fetch_o,
  input  logic [2:0]        la_size_i,
  input  logic [63:0]       la_wdata64_i,
  input  logic [7:0]        la_strb64_i,
  input  logic [31:0]       la_rword_i,
  output logic              tmr_acc_o,
  output logic [ADDR_W-1:0] tmr_addr_o,
  output logic              tmr_write_o,
  output logic [31:0]       tmr_wdata_o,
  input  logic [31:0]       tmr_rdata_i
);

  typedef enum logic [2:0] {
    st_idle, st_timer, st_raddr, st_rdata, st_write, st_bresp
  } state_t;

  state_t state;
  logic   sel_lsu_q;
  logic   arvalid_q;
  logic   awvalid_q;
  logic   wvalid_q;
  logic   tmr_acc_q;
  logic   lsu_tmr_hit;
  logic   aw_clear;
  logic   w_clear;
  logic   resp_err;
  logic   rd_end;
  logic   wr_end;
  logic   tmr_end;

  assign lsu_tmr_hit = (lsu_pay_i.addr == mtime_lo_addr) || (lsu_pay_i.addr == mtime_hi_addr);

  // each write channel is done once its valid is gone or taken now
  assign aw_clear = !awvalid_q || awready_i;
  assign w_clear  = !wvalid_q || wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      sel_lsu_q <= 1'b0;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      tmr_acc_q <= 1'b0;
    end else begin
      tmr_acc_q <= 1'b0;  // strobe lasts one cycle
      case (state)
        st_idle: begin
          if (lsu_pend_i) begin
            sel_lsu_q <= 1'b1;
            if (lsu_tmr_hit) begin
              state     <= st_timer;
              tmr_acc_q <= 1'b1;
            end else if (lsu_pay_i.write) begin
              state     <= st_write;
              awvalid_q <= 1'b1;  // aw and w rise together
              wvalid_q  <= 1'b1;
            end else begin
              state     <= st_raddr;
              arvalid_q <= 1'b1;
            end
          end else if (fetch_pend_i) begin
            sel_lsu_q <= 1'b0;
            state     <= st_raddr;
            arvalid_q <= 1'b1;
          end
        end
        st_timer: if (tmr_end) state <= st_idle;
        st_raddr: begin
          if (arready_i) begin
            arvalid_q <= 1'b0;
            state     <= st_rdata;
          end
        end
        st_rdata: if (rvalid_i) state <= st_idle;
        st_write: begin
          if (awready_i) awvalid_q <= 1'b0;
          if (wready_i) wvalid_q <= 1'b0;
          if (aw_clear && w_clear) state <= st_bresp;
        end
        st_bresp: if (bvalid_i) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // lane aligner sees the granted port
  assign la_addr_o  = sel_lsu_q ? lsu_pay_i.addr : fetch_pay_i.addr;
  assign la_strb_o  = lsu_pay_i.strb;
  assign la_wdata_o = lsu_pay_i.wdata;
  assign la_fetch_o = !sel_lsu_q;

  assign ar_o      = '{addr: la_addr_o, size: la_size_i};
  assign aw_o      = '{addr: la_addr_o, size: la_size_i};
  assign w_o       = '{data: la_wdata64_i, strb: la_strb64_i};
  assign arvalid_o = arvalid_q;
  assign awvalid_o = awvalid_q;
  assign wvalid_o  = wvalid_q;
  assign rready_o  = 1'b1;  // responses never stall
  assign bready_o  = 1'b1;

  assign tmr_acc_o   = tmr_acc_q;
  assign tmr_addr_o  = lsu_pay_i.addr[ADDR_W-1:0];
  assign tmr_write_o = lsu_pay_i.write;
  assign tmr_wdata_o = lsu_pay_i.wdata;

  assign rd_end  = (state == st_rdata) && rvalid_i;
  assign wr_end  = (state == st_bresp) && bvalid_i;
  assign tmr_end = (state == st_timer) && !tmr_acc_q;  // data back one cycle later

  assign resp_err = (state == st_rdata) ? (r_i.resp != resp_okay) : (b_i.resp != resp_okay);

  assign fetch_done_o = rd_end && !sel_lsu_q;
  assign lsu_done_o   = (rd_end && sel_lsu_q) || wr_end || tmr_end;

  assign fetch_rsp_o.data = la_rword_i;
  assign fetch_rsp_o.err  = resp_err;
  assign lsu_rsp_o.rdata  = (state == st_timer) ? tmr_rdata_i : la_rword_i;
  assign lsu_rsp_o.err    = (state == st_timer) ? 1'b0 : resp_err;

endmodule

/* core_bus_top.sv */
`timescale 1ns/1ps

module core_bus_top
  import axi_pkg::*;
  import core_bus_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_req_i,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       fetch_req_valid_i,
  output logic       fetch_ack_o,
  input  lsu_req_t   lsu_req_i,
  output lsu_rsp_t   lsu_rsp_o,
  input  logic       lsu_req_valid_i,
  output logic       lsu_ack_o,
  output axi_ar_t    ar_o,
  output logic       arvalid_o,
  input  logic       arready_i,
  input  axi_r_t     r_i,
  input  logic       rvalid_i,
  output logic       rready_o,
  output axi_aw_t    aw_o,
  output logic       awvalid_o,
  input  logic       awready_i,
  output axi_w_t     w_o,
  output logic       wvalid_o,
  input  logic       wready_i,
  input  axi_b_t     b_i,
  input  logic       bvalid_i,
  output logic       bready_o
);

  logic              fetch_pend, fetch_done;
  fetch_req_t        fetch_pay;
  fetch_rsp_t        fetch_rsp;
  logic              lsu_pend, lsu_done;
  lsu_req_t          lsu_pay;
  lsu_rsp_t          lsu_rsp;
  logic [31:0]       la_addr, la_wdata, la_rword;
  logic [3:0]        la_strb;
  logic              la_fetch;
  logic [2:0]        la_size;
  logic [63:0]       la_wdata64;
  logic [7:0]        la_strb64;
  logic              tmr_acc, tmr_write;
  logic [ADDR_W-1:0] tmr_addr;
  logic [31:0]       tmr_wdata, tmr_rdata;

  req_slot #(.REQ_T(fetch_req_t), .RSP_T(fetch_rsp_t)) fetch_slot (
    .clk(clk), .rst(rst),
    .req_valid_i(fetch_req_valid_i), .req_i(fetch_req_i),
    .ack_o(fetch_ack_o), .rsp_o(fetch_rsp_o),
    .pending_o(fetch_pend), .payload_o(fetch_pay),
    .done_i(fetch_done), .rsp_i(fetch_rsp)
  );

  req_slot #(.REQ_T(lsu_req_t), .RSP_T(lsu_rsp_t)) lsu_slot (
    .clk(clk), .rst(rst),
    .req_valid_i(lsu_req_valid_i), .req_i(lsu_req_i),
    .ack_o(lsu_ack_o), .rsp_o(lsu_rsp_o),
    .pending_o(lsu_pend), .payload_o(lsu_pay),
    .done_i(lsu_done), .rsp_i(lsu_rsp)
  );

  bus_arbiter #(.ADDR_W(ADDR_W)) arb0 (
    .clk(clk), .rst(rst),
    .fetch_pend_i(fetch_pend), .fetch_pay_i(fetch_pay),
    .fetch_done_o(fetch_done), .fetch_rsp_o(fetch_rsp),
    .lsu_pend_i(lsu_pend), .lsu_pay_i(lsu_pay),
    .lsu_done_o(lsu_done), .lsu_rsp_o(lsu_rsp),
    .ar_o(ar_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
    .r_i(r_i), .rvalid_i(rvalid_i),
    .aw_o(aw_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
    .w_o(w_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
    .b_i(b_i), .bvalid_i(bvalid_i),
    .rready_o(rready_o), .bready_o(bready_o),
    .la_addr_o(la_addr), .la_strb_o(la_strb), .la_wdata_o(la_wdata),
    .la_fetch_o(la_fetch), .la_size_i(la_size), .la_wdata64_i(la_wdata64),
    .la_strb64_i(la_strb64), .la_rword_i(la_rword),
    .tmr_acc_o(tmr_acc), .tmr_addr_o(tmr_addr), .tmr_write_o(tmr_write),
    .tmr_wdata_o(tmr_wdata), .tmr_rdata_i(tmr_rdata)
  );

  lane_align align0 (
    .addr_i(la_addr), .strb_i(la_strb), .wdata_i(la_wdata),
    .is_fetch_i(la_fetch), .rdata64_i(r_i.data),
    .size_o(la_size), .wdata64_o(la_wdata64),
    .strb64_o(la_strb64), .rword_o(la_rword)
  );

  clint_timer #(.ADDR_W(ADDR_W)) timer0 (
    .clk(clk), .rst(rst),
    .acc_i(tmr_acc), .addr_i(tmr_addr), .write_i(tmr_write),
    .wdata_i(tmr_wdata), .rdata_o(tmr_rdata)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

// 8 ns clock, synchronous reset held for the first edges
module tb_clk_gen #(
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial clk_o = 1'b0;
  always #4 clk_o = ~clk_o;

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

// sparse 64-bit AXI slave, one beat per transfer
module tb_axi_mem
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] rnd_i,  // fresh random bits each cycle
  input  axi_ar_t    ar_i,
  input  logic       arvalid_i,
  output logic       arready_o,
  output axi_r_t     r_o,
  output logic       rvalid_o,
  input  logic       rready_i,
  input  axi_aw_t    aw_i,
  input  logic       awvalid_i,
  output logic       awready_o,
  input  axi_w_t     w_i,
  input  logic       wvalid_i,
  output logic       wready_o,
  output axi_b_t     b_o,
  output logic       bvalid_o,
  input  logic       bready_i
);

  localparam logic [1:0] resp_slverr = 2'b10;

  logic [63:0] mem [logic [28:0]];
  logic        rd_busy = 1'b0;
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  logic [31:0] rd_addr = '0;
  logic [31:0] wr_addr = '0;
  logic [63:0] wr_data = '0;
  logic [7:0]  wr_strb = '0;
  logic        b_fire;

  initial begin
    rvalid_o = 1'b0;
    bvalid_o = 1'b0;
    r_o      = '0;
    b_o      = '0;
  end

  function automatic logic in_err(input logic [31:0] a);
    return a >= 32'hf000_0000;
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] a);
    if (mem.exists(a[31:3])) begin
      return mem[a[31:3]];
    end
    return {~a[31:3], 3'b000, a[31:3], 3'b100};  // fill from the word address
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] v;
    v = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        v[8*i +: 8] = data[8*i +: 8];
      end
    end
    return v;
  endfunction

  assign arready_o = rnd_i[0] && !rd_busy;
  assign awready_o = rnd_i[1] && !aw_got;
  assign wready_o  = rnd_i[2] && !w_got;
  assign b_fire    = aw_got && w_got && !bvalid_o && rnd_i[3];

  always @(posedge clk) begin
    if (rst) begin
      rd_busy  <= 1'b0;
      rvalid_o <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      if (arvalid_i && arready_o) begin
        rd_busy <= 1'b1;
        rd_addr <= ar_i.addr;
      end
      if (rd_busy && !rvalid_o && rnd_i[3]) begin
        rvalid_o <= 1'b1;
        r_o      <= '{data: read_word(rd_addr),
                      resp: in_err(rd_addr) ? resp_slverr : resp_okay};
      end else if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rd_busy  <= 1'b0;
      end
      if (awvalid_i && awready_o) begin
        aw_got  <= 1'b1;
        wr_addr <= aw_i.addr;
      end
      if (wvalid_i && wready_o) begin
        w_got   <= 1'b1;
        wr_data <= w_i.data;
        wr_strb <= w_i.strb;
      end
      if (b_fire) begin
        bvalid_o <= 1'b1;
        b_o      <= '{resp: in_err(wr_addr) ? resp_slverr : resp_okay};
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end else if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  // error region is never stored
  always @(posedge clk) begin
    if (!rst && b_fire && !in_err(wr_addr)) begin
      mem[wr_addr[31:3]] = merge_bytes(read_word(wr_addr), wr_data, wr_strb);
    end
  end

endmodule

/* core_bus_props.sv */
`timescale 1ns/1ps

// handshake rules seen at the arbiter
module core_bus_props
  import axi_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input axi_ar_t ar_o,
  input logic    arvalid_o,
  input logic    arready_i,
  input axi_aw_t aw_o,
  input logic    awvalid_o,
  input logic    awready_i,
  input axi_w_t  w_o,
  input logic    wvalid_o,
  input logic    wready_i,
  input logic    fetch_pend_i,
  input logic    fetch_done_o,
  input logic    lsu_pend_i,
  input logic    lsu_done_o
);

  ar_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("arvalid or ar payload changed before arready");

  aw_stable: assert property (@(posedge clk) disable iff (rst)
    awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
    else $error("awvalid or aw payload changed before awready");

  w_stable: assert property (@(posedge clk) disable iff (rst)
    wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
    else $error("wvalid or w payload changed before wready");

  one_addr_channel: assert property (@(posedge clk) disable iff (rst)
    !(arvalid_o && awvalid_o))
    else $error("arvalid and awvalid high together");

  // done is what raises ack, so it needs a live request
  fetch_done_req: assert property (@(posedge clk) disable iff (rst)
    fetch_done_o |-> fetch_pend_i)
    else $error("fetch done without a pending request");

  lsu_done_req: assert property (@(posedge clk) disable iff (rst)
    lsu_done_o |-> lsu_pend_i)
    else $error("load/store done without a pending request");

endmodule

bind bus_arbiter core_bus_props props0 (.*);

/* core_bus_tb.sv */
`timescale 1ns/1ps

module core_bus_tb
  import axi_pkg::*;
  import core_bus_pkg::*;
;

  localparam int n_init_a = 64;   // words at 0x1000
  localparam int n_init_b = 32;   // words at 0x1800, fetched later
  localparam int n_mixed = 200;
  localparam int n_fetch = 60;
  localparam int watchdog_cycles = (n_init_a + n_init_b + n_mixed + n_fetch + 12) * 40 + 80;

  logic       clk;
  logic       rst;
  fetch_req_t fetch_req_i = '0;
  fetch_rsp_t fetch_rsp_o;
  logic       fetch_req_valid_i = 1'b0;
  logic       fetch_ack_o;
  lsu_req_t   lsu_req_i = '0;
  lsu_rsp_t   lsu_rsp_o;
  logic       lsu_req_valid_i = 1'b0;
  logic       lsu_ack_o;
  axi_ar_t    ar;
  axi_aw_t    aw;
  axi_w_t     w;
  axi_r_t     r;
  axi_b_t     b;
  logic       arvalid, arready, rvalid, rready;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic [3:0] ready_rnd = '0;
  logic [31:0] lfsr_state = 32'hb51abb3d;
  logic [7:0] model [0:4095];  // byte image of 0x1000..0x1fff
  lsu_req_t   mixed_ops [n_mixed];
  logic [31:0] fetch_addrs [n_fetch];
  int         cycles = 0;

  tb_clk_gen clkgen0 (.clk_o(clk), .rst_o(rst));

  core_bus_top #(.ADDR_W(32)) dut0 (
    .clk(clk), .rst(rst),
    .fetch_req_i(fetch_req_i), .fetch_rsp_o(fetch_rsp_o),
    .fetch_req_valid_i(fetch_req_valid_i), .fetch_ack_o(fetch_ack_o),
    .lsu_req_i(lsu_req_i), .lsu_rsp_o(lsu_rsp_o),
    .lsu_req_valid_i(lsu_req_valid_i), .lsu_ack_o(lsu_ack_o),
    .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
    .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
    .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
    .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
    .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
  );

  tb_axi_mem mem0 (
    .clk(clk), .rst(rst), .rnd_i(ready_rnd),
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
    .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
    .b_o(b), .bvalid_o(bvalid), .bready_i(bready)
  );

  // galois lfsr shifting out one bit per step
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return v;
  endfunction

  // slave readiness changes away from the sampling edge
  always @(negedge clk) ready_rnd <= 4'(rand_bits(4));
  always @(posedge clk) cycles <= cycles + 1;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // axi size is log2 of the bytes touched
  function automatic logic [2:0] size_for_strb(input logic [3:0] strb);
    case ($countones(strb))
      1: return size_byte;
      2: return size_half;
      default: return size_word;
    endcase
  endfunction

  // fetch reads are full words
  always @(posedge clk) begin
    if (!rst && awvalid) begin
      expect_eq("aw_o.size", 64'(aw.size), 64'(size_for_strb(lsu_req_i.strb)));
    end
    if (!rst && arvalid) begin
      if (fetch_req_valid_i && ar.addr == fetch_req_i.addr) begin
        expect_eq("ar_o.size", 64'(ar.size), 64'(size_word));
      end else begin
        expect_eq("ar_o.size", 64'(ar.size), 64'(size_for_strb(lsu_req_i.strb)));
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("watchdog: run not finished after %0d cycles", watchdog_cycles));
  end

  function automatic lsu_req_t make_lsu_req(input logic [31:0] addr, input logic [31:0] wdata,
                                            input logic [3:0] strb, input logic write);
    lsu_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.strb  = strb;
    req.write = write;
    return req;
  endfunction

  // byte, half or word somewhere in 0x1000..0x10ff
  function automatic lsu_req_t random_lsu_op();
    lsu_req_t op;
    logic [1:0] kind;
    kind     = 2'(rand_bits(2));
    op.addr  = 32'h0000_1000 + rand_bits(8);
    op.wdata = rand_bits(32);
    op.write = (rand_bits(1) != 32'd0);
    case (kind)
      2'd0: op.strb = 4'b0001;
      2'd1: begin
        op.strb    = 4'b0011;
        op.addr[0] = 1'b0;
      end
      default: begin
        op.strb      = 4'b1111;
        op.addr[1:0] = 2'b00;
      end
    endcase
    return op;
  endfunction

  task automatic model_store(input lsu_req_t op);
    logic [11:0] base;
    base = op.addr[11:0];
    for (int i = 0; i < 4; i++) begin
      if (op.strb[i]) begin
        model[base + 12'(i)] = op.wdata[8*i +: 8];  // byte i lands at addr + i
      end
    end
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [11:0] b;
    b = {addr[11:2], 2'b00};
    return {model[b + 12'd3], model[b + 12'd2], model[b + 12'd1], model[b]};
  endfunction

  task automatic lsu_access(input lsu_req_t req, output lsu_rsp_t rsp);
    @(posedge clk);
    lsu_req_i       <= req;
    lsu_req_valid_i <= 1'b1;
    do @(posedge clk); while (!lsu_ack_o);
    rsp = lsu_rsp_o;
    lsu_req_valid_i <= 1'b0;
    do @(posedge clk); while (lsu_ack_o);
  endtask

  task automatic fetch_access(input logic [31:0] addr, output fetch_rsp_t rsp);
    @(posedge clk);
    fetch_req_i       <= '{addr: addr};
    fetch_req_valid_i <= 1'b1;
    do @(posedge clk); while (!fetch_ack_o);
    rsp = fetch_rsp_o;
    fetch_req_valid_i <= 1'b0;
    do @(posedge clk); while (fetch_ack_o);
  endtask

  task automatic lsu_checked(input lsu_req_t op);
    lsu_rsp_t rsp;
    lsu_access(op, rsp);
    expect_eq("lsu_rsp_o.err", 64'(rsp.err), 64'd0);
    if (op.write) begin
      model_store(op);
    end else begin
      expect_eq("lsu_rsp_o.rdata", 64'(rsp.rdata), 64'(model_word(op.addr)));
    end
  endtask

  task automatic fetch_checked(input logic [31:0] addr);
    fetch_rsp_t rsp;
    fetch_access(addr, rsp);
    expect_eq("fetch_rsp_o.err", 64'(rsp.err), 64'd0);
    expect_eq("fetch_rsp_o.data", 64'(rsp.data), 64'(model_word(addr)));
  endtask

  // load/store in the low region while fetch reads the high one
  task automatic run_mixed_traffic();
    for (int i = 0; i < n_mixed; i++) begin
      mixed_ops[i] = random_lsu_op();
    end
    for (int i = 0; i < n_fetch; i++) begin
      fetch_addrs[i] = 32'h0000_1800 + 4 * rand_bits(5);
    end
    fork
      begin
        for (int i = 0; i < n_mixed; i++) begin
          lsu_checked(mixed_ops[i]);
        end
      end
      begin
        for (int i = 0; i < n_fetch; i++) begin
          fetch_checked(fetch_addrs[i]);
        end
      end
    join
  endtask

  initial begin
    lsu_rsp_t    rsp;
    fetch_rsp_t  frsp;
    logic [31:0] first_lo;
    logic [31:0] w_lo;
    logic [31:0] w_hi;
    int          t0;
    int          elapsed;

    wait (rst == 1'b0);
    @(posedge clk);
    expect_eq("acks and axi valids after reset",
              64'({fetch_ack_o, lsu_ack_o, arvalid, awvalid, wvalid}), 64'd0);

    lsu_access(make_lsu_req(mtime_lo_addr, '0, 4'hf, 1'b0), rsp);
    first_lo = rsp.rdata;
    lsu_access(make_lsu_req(mtime_lo_addr, '0, 4'hf, 1'b0), rsp);
    if (rsp.rdata < first_lo) begin
      abort_run($sformatf("mtime went backwards from 0x%h to 0x%h", first_lo, rsp.rdata));
    end

    for (int i = 0; i < n_init_a; i++) begin
      lsu_checked(make_lsu_req(32'h0000_1000 + 4 * i, rand_bits(32), 4'hf, 1'b1));
    end
    for (int i = 0; i < n_init_b; i++) begin
      lsu_checked(make_lsu_req(32'h0000_1800 + 4 * i, rand_bits(32), 4'hf, 1'b1));
    end
    run_mixed_traffic();

    // slave error on both ports
    lsu_access(make_lsu_req(32'hf000_0010, '0, 4'hf, 1'b0), rsp);
    expect_eq("lsu_rsp_o.err", 64'(rsp.err), 64'd1);
    lsu_access(make_lsu_req(32'hf000_0104, 32'hdead_0001, 4'hf, 1'b1), rsp);
    expect_eq("lsu_rsp_o.err", 64'(rsp.err), 64'd1);
    fetch_access(32'hf000_0208, frsp);
    expect_eq("fetch_rsp_o.err", 64'(frsp.err), 64'd1);

    w_lo = rand_bits(31);  // top bit clear keeps the carry out of the high word
    w_hi = rand_bits(32);
    t0   = cycles;
    lsu_access(make_lsu_req(mtime_lo_addr, w_lo, 4'hf, 1'b1), rsp);
    expect_eq("lsu_rsp_o.err", 64'(rsp.err), 64'd0);
    lsu_access(make_lsu_req(mtime_hi_addr, w_hi, 4'hf, 1'b1), rsp);
    expect_eq("lsu_rsp_o.err", 64'(rsp.err), 64'd0);
    lsu_access(make_lsu_req(mtime_lo_addr, '0, 4'hf, 1'b0), rsp);
    elapsed = cycles - t0;
    if (rsp.rdata < w_lo || 64'(rsp.rdata) > 64'(w_lo) + 64'(elapsed)) begin
      abort_run($sformatf("mtime low word 0x%h outside 0x%h plus %0d cycles",
                          rsp.rdata, w_lo, elapsed));
    end
    lsu_access(make_lsu_req(mtime_hi_addr, '0, 4'hf, 1'b0), rsp);
    expect_eq("lsu_rsp_o.rdata", 64'(rsp.rdata), 64'(w_hi));

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* compile.f */
axi_pkg.sv
core_bus_pkg.sv
req_slot.sv
lane_align.sv
clint_timer.sv
bus_arbiter.sv
core_bus_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
core_bus_props.sv
core_bus_tb.sv

/* Makefile */
TOP = core_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
